//--- run_sim.sh
#!/bin/sh
# build and run the udp receive testbench, result taken from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module udp_rx_tb \
    -o udp_rx_sim \
    && ./obj_dir/udp_rx_sim | tee sim.log \
    || echo "verilator build or run error"
grep -q "Testbench passed" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sim/udp_rx_props.sv
`timescale 1ns/1ps

module udp_rx_props (
    input logic                 clk,
    input logic                 rst_n,
    input host_pkg::wb_req_t    wb_req,
    input host_pkg::wb_rsp_t    wb_rsp,
    input eth_pkg::fcs_result_t fcs,
    input logic                 pkt_ready
);

    // single-cycle ack
    ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("wishbone ack high for two cycles in a row");

    // a new request is acked on the next cycle
    ack_timing: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wb_req.cyc && wb_req.stb) |=> wb_rsp.ack)
        else $error("wishbone ack not one cycle after cyc and stb");

    ready_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(pkt_ready) |-> $past(fcs.valid))
        else $error("pkt_ready rose without a frame verdict");

endmodule

bind rx_mailbox udp_rx_props props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .fcs       (fcs),
    .pkt_ready (pkt_ready)
);

//--- sim/udp_rx_tb.sv
`timescale 1ns/1ps

module udp_rx_tb;

    typedef struct packed {
        logic       mac_ok;
        logic       ip_ok;
        logic [7:0] proto;
        logic [7:0] len;      // udp payload bytes
        logic       bad_fcs;
        logic       hold;     // packet stays in the mailbox after the row
        logic       accept;
    } case_t;

    localparam int          n_cases  = 13;
    localparam logic [47:0] mac_addr = 48'h02_1a_2b_3c_4d_5e;
    localparam logic [31:0] ip_addr  = 32'hc0_a8_01_64;

    // ****************************************
    // case table
    // ****************************************
    case_t cases [n_cases] = '{
        //  mac   ip    proto  len    fcs   hold  accept
        '{1'b1, 1'b1, 8'd17, 8'd16, 1'b0, 1'b0, 1'b1},
        '{1'b1, 1'b1, 8'd17, 8'd17, 1'b0, 1'b0, 1'b1},
        '{1'b1, 1'b1, 8'd17, 8'd18, 1'b0, 1'b0, 1'b1},
        '{1'b1, 1'b1, 8'd17, 8'd19, 1'b0, 1'b0, 1'b1},
        '{1'b1, 1'b1, 8'd17, 8'd16, 1'b1, 1'b0, 1'b0},   // corrupt fcs
        '{1'b1, 1'b1, 8'd17, 8'd68, 1'b0, 1'b0, 1'b0},   // too long
        '{1'b0, 1'b1, 8'd17, 8'd16, 1'b0, 1'b0, 1'b0},
        '{1'b1, 1'b0, 8'd17, 8'd16, 1'b0, 1'b0, 1'b0},
        '{1'b1, 1'b1, 8'd6,  8'd16, 1'b0, 1'b0, 1'b0},   // tcp
        '{1'b1, 1'b1, 8'd17, 8'd8,  1'b0, 1'b1, 1'b1},
        '{1'b1, 1'b1, 8'd17, 8'd12, 1'b0, 1'b0, 1'b0},   // mailbox still full
        '{1'b1, 1'b1, 8'd17, 8'd20, 1'b0, 1'b0, 1'b1},
        '{1'b1, 1'b1, 8'd17, 8'd64, 1'b0, 1'b0, 1'b1}
    };

    logic              clk = 1'b0;
    logic              rst_n;
    logic              gmii_rx_dv;
    logic [7:0]        gmii_rxd;
    host_pkg::wb_req_t wb_req;
    host_pkg::wb_rsp_t wb_rsp;

    logic [7:0]  frame_q [$];
    logic [31:0] exp_words [$];
    logic [31:0] rng = 32'd24;
    int errors   = 0;
    int accesses = 0;
    int acks     = 0;
    int cycles   = 0;
    int limit    = 0;

    udp_rx_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .board_mac  (mac_addr),
        .board_ip   (ip_addr),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rxd   (gmii_rxd),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (rst_n && wb_rsp.ack)
            acks++;
        if (cycles >= limit) begin
            $display("timeout: run not finished after %0d cycles, errors: %0d", cycles, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // reflected crc-32, one bit at a time
    function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] r;
        logic        fb;
        r = crc;
        for (int i = 0; i < 8; i++) begin
            fb = r[0] ^ b[i];
            r  = {1'b0, r[31:1]} ^ (fb ? 32'hedb8_8320 : 32'd0);
        end
        return r;
    endfunction

    // gmii bytes, gap and the bus accesses of one row
    function automatic int row_cycles(input case_t c);
        int body;
        body = (42 + c.len < 60) ? 60 : 42 + c.len;
        return 8 + body + 4 + 13 + 4 * (5 + (c.len + 3) / 4);
    endfunction

    task automatic push_bytes(input logic [47:0] v, input int n);
        for (int i = n - 1; i >= 0; i--)
            frame_q.push_back(v[8*i +: 8]);
    endtask

    // ****************************************
    // frame builder
    // ****************************************
    task automatic build_frame(input case_t c);
        logic [31:0] crc;
        logic [31:0] w;
        logic [7:0]  b;
        frame_q.delete();
        exp_words.delete();
        w = '0;
        push_bytes({6{eth_pkg::preamble_byte}}, 6);
        push_bytes({eth_pkg::preamble_byte, eth_pkg::sfd_byte}, 2);
        push_bytes(c.mac_ok ? mac_addr : mac_addr ^ 48'h1, 6);
        push_bytes(48'h02_00_00_00_00_01, 6);          // source mac
        push_bytes(eth_pkg::eth_type_ipv4, 2);
        push_bytes({16'h4500, 16'd28 + c.len}, 4);      // ihl 5, total length
        push_bytes(32'h0000_4000, 4);                   // id, don't fragment
        push_bytes({8'h40, c.proto, 16'h0000}, 4);      // ttl, protocol, no checksum
        push_bytes(32'hc0_a8_01_0a, 4);
        push_bytes(c.ip_ok ? ip_addr : ip_addr ^ 32'h1, 4);
        push_bytes(32'h1f90_1f91, 4);                   // ports
        push_bytes({16'd8 + c.len, 16'h0000}, 4);
        for (int i = 0; i < c.len; i++) begin
            rng = next_random(rng);
            b   = rng[7:0];
            frame_q.push_back(b);
            w[31 - 8 * (i % 4) -: 8] = b;   // big-end first
            if (i % 4 == 3 || i == c.len - 1) begin
                exp_words.push_back(w);
                w = '0;
            end
        end
        while (frame_q.size() < 68)
            frame_q.push_back(8'h00);       // pad to minimum frame
        crc = '1;
        for (int i = 8; i < frame_q.size(); i++)
            crc = crc32_step(crc, frame_q[i]);
        crc = ~crc;
        if (c.bad_fcs)
            crc[7:0] = ~crc[7:0];
        push_bytes({crc[7:0], crc[15:8], crc[23:16], crc[31:24]}, 4);  // low byte first
    endtask

    task automatic send_frame();
        foreach (frame_q[i]) begin
            @(posedge clk);
            #2;
            gmii_rx_dv = 1'b1;
            gmii_rxd   = frame_q[i];
        end
        @(posedge clk);
        #2;
        gmii_rx_dv = 1'b0;
        gmii_rxd   = 8'h00;
        repeat (12) @(posedge clk);   // inter-frame gap
    endtask

    // ****************************************
    // wishbone master and checks
    // ****************************************
    task automatic bus_access(input logic we, input host_pkg::wb_reg_e adr,
                              output logic [31:0] rdat);
        @(posedge clk);
        #2;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = 32'h0000_0001;
        accesses++;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        #1;
        wb_req = '0;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            errors++;
            $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic read_check(input host_pkg::wb_reg_e adr, input string name,
                              input logic [31:0] exp);
        logic [31:0] got;
        bus_access(1'b0, adr, got);
        check_value(name, got, exp);
    endtask

    initial begin
        logic [31:0] dummy;
        logic [31:0] good_exp;
        logic [31:0] bad_exp;
        logic [15:0] len_exp;
        logic        ready_exp;
        logic        for_us;
        good_exp  = '0;
        bad_exp   = '0;
        len_exp   = '0;
        ready_exp = 1'b0;
        limit     = 10 + 4 * 5;
        foreach (cases[k])
            limit += row_cycles(cases[k]);
        limit      = 2 * limit;
        rst_n      = 1'b0;
        gmii_rx_dv = 1'b0;
        gmii_rxd   = 8'h00;
        wb_req     = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        read_check(host_pkg::reg_status, "reg_status after reset", 32'd0);
        read_check(host_pkg::reg_data, "reg_data after reset", 32'd0);
        read_check(host_pkg::reg_good_cnt, "reg_good_cnt after reset", 32'd0);
        read_check(host_pkg::reg_bad_cnt, "reg_bad_cnt after reset", 32'd0);
        read_check(host_pkg::reg_release, "reg_release after reset", 32'd0);

        foreach (cases[k]) begin
            build_frame(cases[k]);
            send_frame();
            for_us = cases[k].mac_ok && cases[k].ip_ok &&
                     cases[k].proto == eth_pkg::ip_proto_udp;
            if (cases[k].accept) begin
                good_exp++;
                ready_exp = 1'b1;
                len_exp   = cases[k].len;
            end else if (for_us) begin
                bad_exp++;
                if (!ready_exp)
                    len_exp = cases[k].len;   // held packet keeps its length
            end
            read_check(host_pkg::reg_status, $sformatf("reg_status row %0d", k),
                       {15'd0, ready_exp, len_exp});
            read_check(host_pkg::reg_good_cnt, $sformatf("reg_good_cnt row %0d", k), good_exp);
            read_check(host_pkg::reg_bad_cnt, $sformatf("reg_bad_cnt row %0d", k), bad_exp);
            if (cases[k].accept) begin
                foreach (exp_words[j])
                    read_check(host_pkg::reg_data,
                               $sformatf("reg_data row %0d word %0d", k, j), exp_words[j]);
            end
            if (ready_exp && !cases[k].hold) begin
                bus_access(1'b1, host_pkg::reg_release, dummy);
                ready_exp = 1'b0;
                read_check(host_pkg::reg_status, $sformatf("reg_status release %0d", k),
                           {16'd0, len_exp});
            end
        end

        @(posedge clk);
        #2;
        check_value("wb_rsp.ack count", acks, accesses);
        $display("errors: %0d, bus accesses: %0d", errors, accesses);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- source/eth_pkg.sv
package eth_pkg;

    // ****************************************
    // frame format
    // ****************************************
    localparam logic [7:0]  preamble_byte = 8'h55;
    localparam logic [7:0]  sfd_byte      = 8'hd5;
    localparam logic [15:0] eth_type_ipv4 = 16'h0800;
    localparam logic [3:0]  ip_version    = 4'd4;
    localparam logic [7:0]  ip_proto_udp  = 8'd17;
    localparam logic [7:0]  udp_head_len  = 8'd8;     // bytes

    // reflected ethernet polynomial, register starts at all ones, no final xor
    localparam logic [31:0] crc_poly      = 32'hedb88320;
    localparam logic [31:0] fcs_residue   = 32'hdebb20e3;  // remainder over data plus fcs

    // ****************************************
    // parser states, one-hot
    // ****************************************
    typedef enum logic [6:0] {
        idle     = 7'b000_0001,
        preamble = 7'b000_0010,
        eth_head = 7'b000_0100,
        ip_head  = 7'b000_1000,
        udp_head = 7'b001_0000,
        rx_data  = 7'b010_0000,
        rx_end   = 7'b100_0000
    } parser_state_e;

    // ****************************************
    // byte-stream results
    // ****************************************
    typedef struct packed {
        logic        en;
        logic [31:0] data;    // first payload byte in [31:24]
    } payload_beat_t;

    typedef struct packed {
        logic        done;
        logic [15:0] byte_num;
    } pkt_end_t;

    typedef struct packed {
        logic valid;
        logic ok;
    } fcs_result_t;

endpackage

//--- source/fcs_check.sv
`timescale 1ns/1ps

module fcs_check (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 gmii_rx_dv,
    input  logic [7:0]           gmii_rxd,
    output eth_pkg::fcs_result_t fcs
);

    typedef enum logic [1:0] {
        sync_idle,
        sync_pre,     // inside the preamble
        sync_frame,   // crc running
        sync_wait     // junk, hold until dv drops
    } sync_state_e;

    sync_state_e sync;
    logic [31:0] crc;

    // one byte of the reflected crc, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] d);
        logic [31:0] c;
        c = crc_in ^ {24'd0, d};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ eth_pkg::crc_poly) : (c >> 1);
        end
        return c;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync <= sync_idle;
            crc  <= '1;
            fcs  <= '0;
        end else begin
            fcs.valid <= 1'b0;
            if (!gmii_rx_dv) begin
                if (sync == sync_frame) begin
                    fcs.valid <= 1'b1;
                    fcs.ok    <= (crc == eth_pkg::fcs_residue);
                end
                sync <= sync_idle;
            end else begin
                case (sync)
                    sync_idle: sync <= (gmii_rxd == eth_pkg::preamble_byte) ? sync_pre : sync_wait;
                    sync_pre: begin
                        if (gmii_rxd == eth_pkg::sfd_byte) begin
                            sync <= sync_frame;
                            crc  <= '1;           // sfd itself not covered
                        end else if (gmii_rxd != eth_pkg::preamble_byte) begin
                            sync <= sync_wait;
                        end
                    end
                    sync_frame: crc <= crc_byte(crc, gmii_rxd);
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- source/host_pkg.sv
package host_pkg;

    // ****************************************
    // mailbox sizing
    // ****************************************
    localparam int buf_words = 16;
    localparam int buf_ptr_w = $clog2(buf_words);
    localparam logic [15:0] max_bytes = 16'(buf_words * 4);  // largest payload kept

    localparam int wb_adr_w = 3;

    // word addresses seen by the host
    typedef enum logic [wb_adr_w-1:0] {
        reg_status   = 3'd0,    // ready flag and byte count
        reg_data     = 3'd1,    // payload words, one per read
        reg_good_cnt = 3'd2,
        reg_bad_cnt  = 3'd3,
        reg_release  = 3'd4     // write only
    } wb_reg_e;

    // ****************************************
    // wishbone classic
    // ****************************************
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [wb_adr_w-1:0] adr;
        logic [31:0]         dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

//--- source/rx_mailbox.sv
`timescale 1ns/1ps

module rx_mailbox (
    input  logic                   clk,
    input  logic                   rst_n,
    input  eth_pkg::payload_beat_t beat,
    input  eth_pkg::pkt_end_t      pkt_end,
    input  eth_pkg::fcs_result_t   fcs,
    input  host_pkg::wb_req_t      wb_req,
    output host_pkg::wb_rsp_t      wb_rsp
);

    logic [31:0] buf_mem [host_pkg::buf_words];

    logic [host_pkg::buf_ptr_w:0]   wr_cnt;    // msb set means buffer full
    logic [host_pkg::buf_ptr_w-1:0] rd_ptr;
    logic        pkt_ready;
    logic        done_seen;
    logic        blocked;                      // frame started while mailbox held a packet
    logic [15:0] frame_len;
    logic [31:0] good_cnt;
    logic [31:0] bad_cnt;
    logic        wr_en;
    logic        commit;
    logic        reject;
    logic        wb_hit;
    logic        data_pop;
    logic        release_req;
    logic [31:0] rd_mux;
    host_pkg::wb_reg_e reg_sel;

    assign reg_sel = host_pkg::wb_reg_e'(wb_req.adr);
    assign wb_hit  = wb_req.cyc && wb_req.stb && !wb_rsp.ack;

    assign wr_en  = beat.en && !pkt_ready && !blocked && !wr_cnt[host_pkg::buf_ptr_w];
    assign commit = fcs.valid && fcs.ok && done_seen && !blocked && !pkt_ready &&
                    (frame_len <= host_pkg::max_bytes);
    assign reject = fcs.valid && done_seen && !commit;   // frames for us that failed

    assign data_pop    = wb_hit && !wb_req.we && (reg_sel == host_pkg::reg_data) && pkt_ready;
    assign release_req = wb_hit && wb_req.we && (reg_sel == host_pkg::reg_release);

    // payload store
    always_ff @(posedge clk) begin
        if (wr_en)
            buf_mem[wr_cnt[host_pkg::buf_ptr_w-1:0]] <= beat.data;
    end

    // ****************************************
    // frame verdict and counters
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt    <= '0;
            rd_ptr    <= '0;
            pkt_ready <= 1'b0;
            done_seen <= 1'b0;
            blocked   <= 1'b0;
            frame_len <= '0;
            good_cnt  <= '0;
            bad_cnt   <= '0;
        end else begin
            if (wr_en)
                wr_cnt <= wr_cnt + 1'b1;
            if (pkt_end.done) begin
                done_seen <= 1'b1;
                if (!pkt_ready && !blocked)
                    frame_len <= pkt_end.byte_num;  // keep the held packet's length
            end
            if ((beat.en || pkt_end.done) && pkt_ready)
                blocked <= 1'b1;
            if (data_pop)
                rd_ptr <= rd_ptr + 1'b1;

            if (fcs.valid) begin
                done_seen <= 1'b0;
                blocked   <= 1'b0;
                if (!commit)
                    wr_cnt <= '0;                   // drop partial words
            end
            if (release_req) begin
                pkt_ready <= 1'b0;
                wr_cnt    <= '0;
                rd_ptr    <= '0;
            end
            if (commit) begin
                pkt_ready <= 1'b1;
                good_cnt  <= good_cnt + 32'd1;
            end
            if (reject)
                bad_cnt <= bad_cnt + 32'd1;
        end
    end

    // ****************************************
    // wishbone slave
    // ****************************************
    always_comb begin
        case (reg_sel)
            host_pkg::reg_status:   rd_mux = {15'd0, pkt_ready, frame_len};
            host_pkg::reg_data:     rd_mux = pkt_ready ? buf_mem[rd_ptr] : 32'd0;
            host_pkg::reg_good_cnt: rd_mux = good_cnt;
            host_pkg::reg_bad_cnt:  rd_mux = bad_cnt;
            default:                rd_mux = 32'd0;   // release and unused reads
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_rsp <= '0;
        end else begin
            wb_rsp.ack <= wb_hit;    // single-cycle ack
            if (wb_hit)
                wb_rsp.dat <= wb_req.we ? 32'd0 : rd_mux;
        end
    end

endmodule

//--- source/udp_rx.sv
`timescale 1ns/1ps

module udp_rx (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [47:0]            board_mac,
    input  logic [31:0]            board_ip,
    input  logic                   gmii_rx_dv,
    input  logic [7:0]             gmii_rxd,
    output eth_pkg::payload_beat_t beat,
    output eth_pkg::pkt_end_t      pkt_end
);

    eth_pkg::parser_state_e state;

    logic [5:0]  cnt;          // byte index inside the current header
    logic [5:0]  ihl_bytes;
    logic [47:0] dst_mac;
    logic [7:0]  type_hi;
    logic [7:0]  ip_proto;
    logic [23:0] dst_ip;       // first three bytes, the fourth is compared live
    logic [15:0] udp_len;
    logic [15:0] data_len;
    logic [15:0] data_cnt;
    logic [15:0] udp_min;
    logic [31:0] word;
    logic [31:0] word_next;
    logic        last_byte;
    logic        beat_en;
    logic        done;

    assign udp_min   = {8'd0, eth_pkg::udp_head_len};
    assign last_byte = (state == eth_pkg::rx_data) && gmii_rx_dv &&
                       (data_cnt == data_len - 16'd1);

    // byte lane fill, a new word starts with its low bytes cleared
    always_comb begin
        case (data_cnt[1:0])
            2'd0:    word_next = {gmii_rxd, 24'd0};
            2'd1:    word_next = {word[31:24], gmii_rxd, 16'd0};
            2'd2:    word_next = {word[31:16], gmii_rxd, 8'd0};
            default: word_next = {word[31:8], gmii_rxd};
        endcase
    end

    // ****************************************
    // header walk
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= eth_pkg::idle;
            cnt      <= '0;
            data_cnt <= '0;
            beat_en  <= 1'b0;
            done     <= 1'b0;
        end else begin
            beat_en <= 1'b0;
            done    <= 1'b0;
            cnt     <= cnt + 6'd1;
            if (!gmii_rx_dv) begin
                state    <= eth_pkg::idle;   // end of frame or abort
                cnt      <= '0;
                data_cnt <= '0;
            end else begin
                case (state)
                    eth_pkg::idle: begin
                        if (gmii_rxd == eth_pkg::preamble_byte)
                            state <= eth_pkg::preamble;
                        else
                            state <= eth_pkg::rx_end;
                    end
                    eth_pkg::preamble: begin
                        // seven 0x55 then the sfd
                        if (gmii_rxd == eth_pkg::sfd_byte && cnt == 6'd7) begin
                            state <= eth_pkg::eth_head;
                            cnt   <= '0;
                        end else if (gmii_rxd != eth_pkg::preamble_byte || cnt == 6'd7) begin
                            state <= eth_pkg::rx_end;
                        end
                    end
                    eth_pkg::eth_head: begin
                        if (cnt == 6'd13) begin
                            cnt <= '0;
                            if (dst_mac == board_mac &&
                                {type_hi, gmii_rxd} == eth_pkg::eth_type_ipv4)
                                state <= eth_pkg::ip_head;
                            else
                                state <= eth_pkg::rx_end;
                        end
                    end
                    eth_pkg::ip_head: begin
                        if (cnt == 6'd0 && (gmii_rxd[7:4] != eth_pkg::ip_version ||
                                            gmii_rxd[3:0] < 4'd5)) begin
                            state <= eth_pkg::rx_end;
                        end else if (cnt == 6'd19 && (ip_proto != eth_pkg::ip_proto_udp ||
                                                      {dst_ip, gmii_rxd} != board_ip)) begin
                            state <= eth_pkg::rx_end;
                        end else if (cnt >= 6'd19 && cnt == ihl_bytes - 6'd1) begin
                            state <= eth_pkg::udp_head;   // options skipped
                            cnt   <= '0;
                        end
                    end
                    eth_pkg::udp_head: begin
                        if (cnt == 6'd7) begin
                            cnt      <= '0;
                            data_cnt <= '0;
                            state    <= (udp_len > udp_min) ? eth_pkg::rx_data : eth_pkg::rx_end;
                        end
                    end
                    eth_pkg::rx_data: begin
                        data_cnt <= data_cnt + 16'd1;
                        beat_en  <= (data_cnt[1:0] == 2'd3) || last_byte;
                        if (last_byte) begin
                            done  <= 1'b1;
                            state <= eth_pkg::rx_end;   // padding and fcs ignored
                        end
                    end
                    eth_pkg::rx_end: ;                  // wait for dv to drop
                    default: state <= eth_pkg::idle;
                endcase
            end
        end
    end

    // ****************************************
    // field capture and payload packing
    // ****************************************
    always_ff @(posedge clk) begin
        if (gmii_rx_dv) begin
            case (state)
                eth_pkg::eth_head: begin
                    if (cnt < 6'd6)
                        dst_mac <= {dst_mac[39:0], gmii_rxd};
                    if (cnt == 6'd12)
                        type_hi <= gmii_rxd;
                end
                eth_pkg::ip_head: begin
                    if (cnt == 6'd0)
                        ihl_bytes <= {gmii_rxd[3:0], 2'b00};  // words to bytes
                    if (cnt == 6'd9)
                        ip_proto <= gmii_rxd;
                    if (cnt >= 6'd16 && cnt <= 6'd18)
                        dst_ip <= {dst_ip[15:0], gmii_rxd};
                end
                eth_pkg::udp_head: begin
                    if (cnt == 6'd4)
                        udp_len[15:8] <= gmii_rxd;
                    if (cnt == 6'd5)
                        udp_len[7:0] <= gmii_rxd;
                    if (cnt == 6'd7)
                        data_len <= udp_len - udp_min;
                end
                eth_pkg::rx_data: word <= word_next;
                default: ;
            endcase
        end
    end

    assign beat.en          = beat_en;
    assign beat.data        = word;
    assign pkt_end.done     = done;
    assign pkt_end.byte_num = data_len;

endmodule

//--- source/udp_rx_top.sv
`timescale 1ns/1ps

module udp_rx_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [47:0]       board_mac,
    input  logic [31:0]       board_ip,
    input  logic              gmii_rx_dv,
    input  logic [7:0]        gmii_rxd,
    input  host_pkg::wb_req_t wb_req,
    output host_pkg::wb_rsp_t wb_rsp
);

    eth_pkg::payload_beat_t beat;
    eth_pkg::pkt_end_t      pkt_end;
    eth_pkg::fcs_result_t   fcs;

    // header parse and crc run side by side on the same bytes
    udp_rx udp_rx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .board_mac  (board_mac),
        .board_ip   (board_ip),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rxd   (gmii_rxd),
        .beat       (beat),
        .pkt_end    (pkt_end)
    );

    fcs_check fcs_check_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rxd   (gmii_rxd),
        .fcs        (fcs)
    );

    rx_mailbox rx_mailbox_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .beat    (beat),
        .pkt_end (pkt_end),
        .fcs     (fcs),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp)
    );

endmodule

//--- verilog.f
source/eth_pkg.sv
source/host_pkg.sv
source/udp_rx.sv
source/fcs_check.sv
source/rx_mailbox.sv
source/udp_rx_top.sv
sim/udp_rx_props.sv
sim/udp_rx_tb.sv
